/* verilog/tlb_pkg.sv */
package tlb_pkg;

    ////////////////////////////////
    // TLB geometry
    localparam int TLB_WAYS  = 2;
    localparam int TLB_DEPTH = 16;
    localparam int TLB_IDX_W = $clog2(TLB_DEPTH);
    // VPN bits left over after the set index
    localparam int TLB_TAG_W = 20 - TLB_IDX_W;

    // Access kinds
    localparam logic [1:0] KIND_READ  = 2'd0;
    localparam logic [1:0] KIND_WRITE = 2'd1;
    localparam logic [1:0] KIND_EXEC  = 2'd2;

    // Configuration register map
    localparam int         CFG_ADDR_W  = 2;
    localparam logic [1:0] CFG_PT_BASE = 2'd0;
    localparam logic [1:0] CFG_ENABLE  = 2'd1;
    localparam logic [1:0] CFG_FLUSH   = 2'd2;

    ////////////////////////////////
    // Stored entry, one per way and set
    typedef struct packed {
        logic                 valid;
        logic [TLB_TAG_W-1:0] tag;
        logic [19:0]          ppn;
        logic                 r;
        logic                 w;
        logic                 x;
    } tlb_entry_t;

    // Lookup view of a virtual address
    typedef struct packed {
        logic [TLB_TAG_W-1:0] tag;
        logic [TLB_IDX_W-1:0] idx;
        logic [11:0]          offset;
    } va_tlb_t;

    // Page table view of the same word
    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] offset;
    } va_pt_t;

    typedef union packed {
        va_tlb_t tlb_view;
        va_pt_t  pt_view;
    } vaddr_u;

    typedef struct packed {
        vaddr_u     vaddr;
        logic [1:0] kind;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        fault;
        logic [1:0]  cause;
    } xlate_rsp_t;

    // Permission bit that matches the access kind
    function automatic logic kind_allowed(input logic [1:0] kind, input logic r,
                                          input logic w, input logic x);
        logic ok;
        case (kind)
            KIND_READ:  ok = r;
            KIND_WRITE: ok = w;
            KIND_EXEC:  ok = x;
            default:    ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage

/* verilog/sv32_pkg.sv */
package sv32_pkg;

    ////////////////////////////////
    // Page table entry, Sv32 bit positions
    typedef struct packed {
        // Top PPN bits dropped, physical space is 32 bits
        logic [1:0]  rsvd_hi;
        logic [19:0] ppn;
        // RSW, D, A, G, U all unused here
        logic [5:0]  rsvd_lo;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef enum logic [1:0] {
        FAULT_NONE    = 2'd0,
        FAULT_INVALID = 2'd1,
        FAULT_PERM    = 2'd2
    } fault_e;

    ////////////////////////////////
    // Walker memory read request
    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    // Walker result written back into the TLB
    typedef struct packed {
        logic [19:0] ppn;
        logic        r;
        logic        w;
        logic        x;
    } refill_t;

endpackage

/* verilog/tlb_lutram.sv */
`timescale 1ns/1ps

module tlb_lutram (
    input  logic                          clk,
    input  logic                          we,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] waddr,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] raddr,
    input  tlb_pkg::tlb_entry_t           wdata,
    output tlb_pkg::tlb_entry_t           rdata
);

    // One way, maps onto distributed RAM
    tlb_pkg::tlb_entry_t mem [tlb_pkg::TLB_DEPTH];

    // Power-up contents, all entries invalid
    initial begin
        for (int i = 0; i < tlb_pkg::TLB_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read
    assign rdata = mem[raddr];

endmodule

/* verilog/tlb.sv */
`timescale 1ns/1ps

module tlb (
    input  logic                          clk,
    input  logic                          rst,
    input  tlb_pkg::xlate_req_t           req,
    input  logic                          req_valid,
    output logic                          req_ready,
    output tlb_pkg::xlate_rsp_t           rsp,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    input  logic                          xlat_en,
    input  logic                          flush_active,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] flush_idx,
    output tlb_pkg::vaddr_u               walk_vaddr,
    output logic [1:0]                    walk_kind,
    output logic                          walk_valid,
    input  logic                          walk_done,
    input  sv32_pkg::refill_t             walk_refill,
    input  sv32_pkg::fault_e              walk_fault
);

    typedef enum logic [1:0] {S_IDLE, S_WALK, S_RELOOK, S_RESP} state_e;

    state_e                              state;
    tlb_pkg::xlate_req_t                 cur;
    tlb_pkg::vaddr_u                     look_va;
    logic [1:0]                          look_kind;
    tlb_pkg::tlb_entry_t                 way_q [tlb_pkg::TLB_WAYS];
    tlb_pkg::tlb_entry_t                 wr_entry;
    tlb_pkg::xlate_rsp_t                 hit_rsp;
    logic [tlb_pkg::TLB_WAYS-1:0]        tag_hit;
    logic [tlb_pkg::TLB_WAYS-1:0]        way_we;
    logic [tlb_pkg::TLB_WAYS-1:0]        rr_way;
    logic [tlb_pkg::TLB_IDX_W-1:0]       wr_idx;
    logic                                hit;
    logic                                accept;
    logic                                refill_we;
    logic [19:0]                         hit_ppn;
    logic                                hit_r;
    logic                                hit_w;
    logic                                hit_x;

    ////////////////////////////////
    // Lookup
    // Incoming request while idle, held request otherwise
    assign look_va   = (state == S_IDLE) ? req.vaddr : cur.vaddr;
    assign look_kind = (state == S_IDLE) ? req.kind : cur.kind;

    // Flush owns the write port, refill write dropped if they meet
    assign refill_we = (state == S_WALK) & walk_done & (walk_fault == sv32_pkg::FAULT_NONE);
    assign wr_idx    = flush_active ? flush_idx : cur.vaddr.tlb_view.idx;
    assign way_we    = flush_active ? '1 : (refill_we ? rr_way : '0);

    always_comb begin
        wr_entry       = '0;
        if (!flush_active) begin
            wr_entry.valid = 1'b1;
            wr_entry.tag   = cur.vaddr.tlb_view.tag;
            wr_entry.ppn   = walk_refill.ppn;
            wr_entry.r     = walk_refill.r;
            wr_entry.w     = walk_refill.w;
            wr_entry.x     = walk_refill.x;
        end
    end

    for (genvar i = 0; i < tlb_pkg::TLB_WAYS; i++) begin : g_way
        tlb_lutram u_ram (
            .clk   (clk),
            .we    (way_we[i]),
            .waddr (wr_idx),
            .raddr (look_va.tlb_view.idx),
            .wdata (wr_entry),
            .rdata (way_q[i])
        );
        assign tag_hit[i] = way_q[i].valid & (way_q[i].tag == look_va.tlb_view.tag);
    end

    assign hit = |tag_hit;

    // OR-mux of the hitting way, at most one
    always_comb begin
        hit_ppn = '0;
        hit_r   = 1'b0;
        hit_w   = 1'b0;
        hit_x   = 1'b0;
        for (int i = 0; i < tlb_pkg::TLB_WAYS; i++) begin
            if (tag_hit[i]) begin
                hit_ppn |= way_q[i].ppn;
                hit_r   |= way_q[i].r;
                hit_w   |= way_q[i].w;
                hit_x   |= way_q[i].x;
            end
        end
    end

    // Cached entry may lack the bit for this kind
    always_comb begin
        hit_rsp.paddr = {hit_ppn, look_va.tlb_view.offset};
        hit_rsp.fault = 1'b0;
        hit_rsp.cause = sv32_pkg::FAULT_NONE;
        if (!tlb_pkg::kind_allowed(look_kind, hit_r, hit_w, hit_x)) begin
            hit_rsp.paddr = '0;
            hit_rsp.fault = 1'b1;
            hit_rsp.cause = sv32_pkg::FAULT_PERM;
        end
    end

    ////////////////////////////////
    // Handshakes
    assign req_ready  = (state == S_IDLE) & ~flush_active;
    assign accept     = req_valid & req_ready;
    assign rsp_valid  = (state == S_RESP);
    // Walker never starts during a flush
    assign walk_valid = (state == S_WALK) & ~flush_active;
    assign walk_vaddr = cur.vaddr;
    assign walk_kind  = cur.kind;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            rr_way <= tlb_pkg::TLB_WAYS'(1);
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= (!xlat_en || hit) ? S_RESP : S_WALK;
                    end
                end
                S_WALK: begin
                    if (walk_done) begin
                        state <= (walk_fault == sv32_pkg::FAULT_NONE) ? S_RELOOK : S_RESP;
                    end
                end
                // Flush may have wiped the refill, walk again
                S_RELOOK: begin
                    if (!flush_active) begin
                        state <= hit ? S_RESP : S_WALK;
                    end
                end
                S_RESP: begin
                    if (rsp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
            // Round-robin victim pointer
            if (refill_we && !flush_active) begin
                rr_way <= {rr_way[tlb_pkg::TLB_WAYS-2:0], rr_way[tlb_pkg::TLB_WAYS-1]};
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= req;
        end
        if (accept && !xlat_en) begin
            rsp.paddr <= req.vaddr;
            rsp.fault <= 1'b0;
            rsp.cause <= sv32_pkg::FAULT_NONE;
        end else if (accept && hit) begin
            rsp <= hit_rsp;
        end else if (state == S_WALK && walk_done && walk_fault != sv32_pkg::FAULT_NONE) begin
            rsp.paddr <= '0;
            rsp.fault <= 1'b1;
            rsp.cause <= walk_fault;
        end else if (state == S_RELOOK && !flush_active && hit) begin
            rsp <= hit_rsp;
        end
    end

endmodule

/* verilog/page_walker.sv */
`timescale 1ns/1ps

module page_walker (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        pt_base,
    input  tlb_pkg::vaddr_u    walk_vaddr,
    input  logic [1:0]         walk_kind,
    input  logic               walk_valid,
    output logic               walk_done,
    output sv32_pkg::refill_t  walk_refill,
    output sv32_pkg::fault_e   walk_fault,
    output sv32_pkg::mem_req_t mem_req,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    input  logic [31:0]        mem_rdata,
    input  logic               mem_rsp_valid
);

    typedef enum logic [1:0] {W_IDLE, W_REQ, W_WAIT} wstate_e;

    wstate_e        state;
    sv32_pkg::pte_t pte;

    ////////////////////////////////
    // Walk FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (walk_valid) begin
                        state <= W_REQ;
                    end
                end
                W_REQ: begin
                    if (mem_req_ready) begin
                        state <= W_WAIT;
                    end
                end
                // One outstanding read, response cannot stall
                W_WAIT: begin
                    if (mem_rsp_valid) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Single level table, 4 bytes per PTE
    always_ff @(posedge clk) begin
        if (state == W_IDLE && walk_valid) begin
            mem_req.addr <= pt_base + {10'd0, walk_vaddr.pt_view.vpn, 2'b00};
        end
    end

    assign mem_req_valid = (state == W_REQ);

    ////////////////////////////////
    // PTE decode
    assign pte = sv32_pkg::pte_t'(mem_rdata);

    assign walk_refill.ppn = pte.ppn;
    assign walk_refill.r   = pte.r;
    assign walk_refill.w   = pte.w;
    assign walk_refill.x   = pte.x;

    always_comb begin
        if (!pte.v) begin
            walk_fault = sv32_pkg::FAULT_INVALID;
        end else if (!tlb_pkg::kind_allowed(walk_kind, pte.r, pte.w, pte.x)) begin
            walk_fault = sv32_pkg::FAULT_PERM;
        end else begin
            walk_fault = sv32_pkg::FAULT_NONE;
        end
    end

    // Same cycle as the read data, TLB leaves its walk state on it
    assign walk_done = (state == W_WAIT) & mem_rsp_valid;

endmodule

/* verilog/mmu_ctrl.sv */
`timescale 1ns/1ps

module mmu_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cfg_valid,
    output logic                           cfg_ready,
    input  logic [tlb_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]                    cfg_wdata,
    output logic [31:0]                    pt_base,
    output logic                           xlat_en,
    output logic                           flush_active,
    output logic [tlb_pkg::TLB_IDX_W-1:0]  flush_idx
);

    logic cfg_we;

    // No writes taken while sets are being cleared
    assign cfg_ready = ~flush_active;
    assign cfg_we    = cfg_valid & cfg_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pt_base      <= '0;
            xlat_en      <= 1'b0;
            flush_active <= 1'b0;
            flush_idx    <= '0;
        end else begin
            if (cfg_we) begin
                case (cfg_addr)
                    tlb_pkg::CFG_PT_BASE: pt_base <= cfg_wdata;
                    tlb_pkg::CFG_ENABLE:  xlat_en <= cfg_wdata[0];
                    tlb_pkg::CFG_FLUSH: begin
                        flush_active <= 1'b1;
                        flush_idx    <= '0;
                    end
                    default: ;
                endcase
            end
            // One set per cycle, TLB_DEPTH cycles in total
            if (flush_active) begin
                flush_idx <= flush_idx + 1'b1;
                if (flush_idx == tlb_pkg::TLB_IDX_W'(tlb_pkg::TLB_DEPTH - 1)) begin
                    flush_active <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  tlb_pkg::xlate_req_t            req,
    input  logic                           req_valid,
    output logic                           req_ready,
    output tlb_pkg::xlate_rsp_t            rsp,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output sv32_pkg::mem_req_t             mem_req,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    input  logic [31:0]                    mem_rdata,
    input  logic                           mem_rsp_valid,
    input  logic                           cfg_valid,
    output logic                           cfg_ready,
    input  logic [tlb_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]                    cfg_wdata
);

    ////////////////////////////////
    // Control to TLB and walker
    logic [31:0]                   pt_base;
    logic                          xlat_en;
    logic                          flush_active;
    logic [tlb_pkg::TLB_IDX_W-1:0] flush_idx;

    // TLB to walker
    tlb_pkg::vaddr_u               walk_vaddr;
    logic [1:0]                    walk_kind;
    logic                          walk_valid;
    logic                          walk_done;
    sv32_pkg::refill_t             walk_refill;
    sv32_pkg::fault_e              walk_fault;

    mmu_ctrl u_mmu_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .pt_base      (pt_base),
        .xlat_en      (xlat_en),
        .flush_active (flush_active),
        .flush_idx    (flush_idx)
    );

    tlb u_tlb (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .xlat_en      (xlat_en),
        .flush_active (flush_active),
        .flush_idx    (flush_idx),
        .walk_vaddr   (walk_vaddr),
        .walk_kind    (walk_kind),
        .walk_valid   (walk_valid),
        .walk_done    (walk_done),
        .walk_refill  (walk_refill),
        .walk_fault   (walk_fault)
    );

    page_walker u_page_walker (
        .clk           (clk),
        .rst           (rst),
        .pt_base       (pt_base),
        .walk_vaddr    (walk_vaddr),
        .walk_kind     (walk_kind),
        .walk_valid    (walk_valid),
        .walk_done     (walk_done),
        .walk_refill   (walk_refill),
        .walk_fault    (walk_fault),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata),
        .mem_rsp_valid (mem_rsp_valid)
    );

endmodule

/* dv/mmu_sva.sv */
`timescale 1ns/1ps

module mmu_sva #(
    parameter int DATA_W = 32
) (
    input logic                         clk,
    input logic                         rst,
    input logic [tlb_pkg::TLB_WAYS-1:0] hit_vec,
    input logic                         hold_valid,
    input logic                         hold_ready,
    input logic [DATA_W-1:0]            hold_data,
    input logic                         busy,
    input logic                         start
);

    ////////////////////////////////
    // At most one way matches a tag
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("more than one TLB way hit at once");

    // Valid stays up with a stable payload until the transfer
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        hold_valid && !hold_ready |=> hold_valid && $stable(hold_data))
        else $error("valid dropped or payload changed before transfer");

    // No walk starts while sets are being cleared
    a_no_walk_in_flush: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else $error("walk requested during flush");

endmodule

// Response side of the TLB
bind tlb mmu_sva #(.DATA_W($bits(tlb_pkg::xlate_rsp_t))) u_tlb_sva (
    .clk        (clk),
    .rst        (rst),
    .hit_vec    (tag_hit),
    .hold_valid (rsp_valid),
    .hold_ready (rsp_ready),
    .hold_data  (rsp),
    .busy       (flush_active),
    .start      (walk_valid)
);

// Memory request side of the walker
bind page_walker mmu_sva #(.DATA_W($bits(sv32_pkg::mem_req_t))) u_walker_sva (
    .clk        (clk),
    .rst        (rst),
    .hit_vec    ({tlb_pkg::TLB_WAYS{1'b0}}),
    .hold_valid (mem_req_valid),
    .hold_ready (mem_req_ready),
    .hold_data  (mem_req),
    .busy       (1'b0),
    .start      (1'b0)
);

/* dv/tb_mmu.sv */
`timescale 1ns/1ps

module tb_mmu;

    ////////////////////////////////
    // Run parameters
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] SEED       = 32'd10182;
    localparam logic [31:0] PT_BASE    = 32'h0001_0000;
    localparam int          PT_ENTRIES = 64;

    // Operation counts per test phase
    localparam int N_BYPASS = 20;
    localparam int N_MISS   = 8;
    localparam int N_FAULT  = 6;
    localparam int N_FLUSH  = 3;
    localparam int N_BP     = 40;
    localparam int N_REPL   = 24;
    localparam int N_CFG    = 3;
    localparam int N_OPS    = N_BYPASS + 2 * N_MISS + N_FAULT + N_FLUSH + N_BP + N_REPL + N_CFG;
    // Generous per-operation budget
    localparam int WATCHDOG_CYCLES = N_OPS * 40;

    logic                           clk;
    logic                           rst;
    tlb_pkg::xlate_req_t            req;
    logic                           req_valid;
    logic                           req_ready;
    tlb_pkg::xlate_rsp_t            rsp;
    logic                           rsp_valid;
    logic                           rsp_ready;
    sv32_pkg::mem_req_t             mem_req;
    logic                           mem_req_valid;
    logic                           mem_req_ready;
    logic [31:0]                    mem_rdata;
    logic                           mem_rsp_valid;
    logic                           cfg_valid;
    logic                           cfg_ready;
    logic [tlb_pkg::CFG_ADDR_W-1:0] cfg_addr;
    logic [31:0]                    cfg_wdata;

    // Page table as seen by the memory model
    logic [31:0] pt_mem [PT_ENTRIES];
    // Separate streams for stimulus and memory timing
    logic [31:0] rng;
    logic [31:0] mem_rng;
    // Enable bit last written through cfg
    logic        model_en;
    int          mem_reads;
    int          n_checks;
    int          n_errors;

    mmu_top u_mmu_top (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata),
        .mem_rsp_valid (mem_rsp_valid),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////
    // Random numbers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Value in 0..n-1 from the upper state bits
    function automatic int pick(input int n);
        rng = lcg_next(rng);
        return int'(rng[31:8] % n);
    endfunction

    function automatic logic [31:0] random_word();
        logic [15:0] hi;
        rng = lcg_next(rng);
        hi  = rng[31:16];
        rng = lcg_next(rng);
        return {hi, rng[31:16]};
    endfunction

    // Address inside a given page, random offset
    function automatic logic [31:0] page_addr(input int vpn);
        logic [11:0] offset;
        offset = 12'(pick(4096));
        return {14'd0, 6'(vpn), offset};
    endfunction

    // Sv32 layout: PPN at 29:10, then X W R V in bits 3:0
    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic r,
                                             input logic w, input logic x, input logic v);
        return {2'b00, ppn, 6'b000000, x, w, r, v};
    endfunction

    ////////////////////////////////
    // Reference translation
    function automatic tlb_pkg::xlate_rsp_t ref_translate(input logic [31:0] va,
                                                         input logic [1:0] kind);
        tlb_pkg::xlate_rsp_t r;
        logic [31:0]         pte;
        logic                perm;
        r = '0;
        if (!model_en) begin
            r.paddr = va;
            return r;
        end
        pte = pt_mem[va[17:12]];
        case (kind)
            2'd0:    perm = pte[1];
            2'd1:    perm = pte[2];
            2'd2:    perm = pte[3];
            default: perm = 1'b0;
        endcase
        if (!pte[0]) begin
            r.fault = 1'b1;
            r.cause = sv32_pkg::FAULT_INVALID;
        end else if (!perm) begin
            r.fault = 1'b1;
            r.cause = sv32_pkg::FAULT_PERM;
        end else begin
            r.paddr = {pte[29:10], va[11:0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED %s: actual 0x%08h expected 0x%08h at %0t", name, act, exp, $time);
        end
    endtask

    ////////////////////////////////
    // Bus tasks
    task automatic cfg_write(input logic [tlb_pkg::CFG_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        do begin
            @(posedge clk);
        end while (!cfg_ready);
        cfg_valid <= 1'b0;
    endtask

    task automatic flush_tlb();
        int busy_cycles;
        busy_cycles = 0;
        cfg_write(tlb_pkg::CFG_FLUSH, 32'd0);
        // cfg_ready comes back once every set is cleared
        do begin
            @(posedge clk);
            if (!cfg_ready) begin
                busy_cycles++;
            end
        end while (!cfg_ready);
        // One set per cycle
        check("cfg_ready low cycles", 32'(busy_cycles), 32'd16);
    endtask

    // One translation start to finish, exp_reads below 0 skips the read count
    task automatic translate(input logic [31:0] va, input logic [1:0] kind, input bit stall,
                             input int exp_reads);
        tlb_pkg::xlate_rsp_t exp;
        tlb_pkg::xlate_rsp_t got;
        int                  reads_before;
        bit                  done;
        exp          = ref_translate(va, kind);
        reads_before = mem_reads;
        done         = 1'b0;
        got          = '0;
        @(posedge clk);
        req_valid <= 1'b1;
        req.vaddr <= va;
        req.kind  <= kind;
        rsp_ready <= stall ? (pick(2) == 1) : 1'b1;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        // Random stalls on the response side
        while (!done) begin
            @(posedge clk);
            if (rsp_valid && rsp_ready) begin
                got  = rsp;
                done = 1'b1;
            end else begin
                rsp_ready <= stall ? (pick(2) == 1) : 1'b1;
            end
        end
        rsp_ready <= 1'b0;
        check("rsp.fault", 32'(got.fault), 32'(exp.fault));
        check("rsp.cause", 32'(got.cause), 32'(exp.cause));
        // Address only defined without a fault
        if (!exp.fault) begin
            check("rsp.paddr", got.paddr, exp.paddr);
        end
        if (exp_reads >= 0) begin
            check("mem_reads", 32'(mem_reads - reads_before), 32'(exp_reads));
        end
    endtask

    ////////////////////////////////
    // Memory model
    initial begin : mem_model
        int          delay;
        int          idx;
        bit          pending;
        logic [31:0] offs;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        mem_rng       = ~SEED;
        pending       = 1'b0;
        delay         = 0;
        idx           = 0;
        forever begin
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
            mem_rng = lcg_next(mem_rng);
            if (rst) begin
                pending = 1'b0;
                mem_req_ready <= 1'b0;
            end else if (pending) begin
                delay--;
                if (delay == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rdata     <= pt_mem[idx];
                    pending = 1'b0;
                end
            end else if (mem_req_valid && mem_req_ready) begin
                mem_reads++;
                offs = mem_req.addr - PT_BASE;
                if (offs[1:0] != 2'b00 || offs >= 4 * PT_ENTRIES) begin
                    n_errors++;
                    $display("Walker read outside the page table at address 0x%08h",
                             mem_req.addr);
                end
                idx     = int'(offs[7:2]);
                // 1 to 4 cycles until the data shows up
                delay   = 1 + int'(mem_rng[31:8] % 4);
                pending = 1'b1;
                mem_req_ready <= 1'b0;
            end else begin
                mem_req_ready <= mem_rng[20];
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////
    // Test sequence
    initial begin
        tlb_pkg::xlate_rsp_t first;
        logic [31:0]         word;
        logic [31:0]         va;
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rng       = SEED;
        model_en  = 1'b0;
        mem_reads = 0;
        n_checks  = 0;
        n_errors  = 0;

        // Random table, mostly valid
        for (int i = 0; i < PT_ENTRIES; i++) begin
            word      = random_word();
            pt_mem[i] = make_pte(word[19:0], word[20], word[21], word[22], pick(8) != 0);
        end
        // Fixed entries for the directed phases
        pt_mem[10] = make_pte(20'h0_0abc, 1'b1, 1'b1, 1'b1, 1'b0);
        pt_mem[11] = make_pte(20'h1_2345, 1'b1, 1'b0, 1'b0, 1'b1);
        pt_mem[30] = make_pte(20'h3_0030, 1'b1, 1'b1, 1'b1, 1'b1);
        // Same set 5 for all three
        pt_mem[5]  = make_pte(20'h5_0005, 1'b1, 1'b1, 1'b1, 1'b1);
        pt_mem[21] = make_pte(20'h5_0021, 1'b1, 1'b1, 1'b1, 1'b1);
        pt_mem[37] = make_pte(20'h5_0037, 1'b1, 1'b1, 1'b1, 1'b1);

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Bypass
        for (int i = 0; i < N_BYPASS; i++) begin
            translate(random_word(), 2'(pick(3)), 1'b0, 0);
        end

        cfg_write(tlb_pkg::CFG_PT_BASE, PT_BASE);
        cfg_write(tlb_pkg::CFG_ENABLE, 32'd1);
        model_en = 1'b1;

        // Miss then hit, a fault caches nothing
        for (int i = 0; i < N_MISS; i++) begin
            va    = page_addr(20 + i);
            first = ref_translate(va, tlb_pkg::KIND_READ);
            translate(va, tlb_pkg::KIND_READ, 1'b0, 1);
            translate(page_addr(20 + i), tlb_pkg::KIND_READ, 1'b0, first.fault ? 1 : 0);
        end

        // Faults
        translate(page_addr(10), tlb_pkg::KIND_READ, 1'b0, 1);
        translate(page_addr(10), tlb_pkg::KIND_READ, 1'b0, 1);
        translate(page_addr(11), tlb_pkg::KIND_WRITE, 1'b0, 1);
        translate(page_addr(11), tlb_pkg::KIND_WRITE, 1'b0, 1);
        translate(page_addr(11), tlb_pkg::KIND_READ, 1'b0, 1);
        // Cached entry without X
        translate(page_addr(11), tlb_pkg::KIND_EXEC, 1'b0, 0);

        // Flush picks up the new mapping
        translate(page_addr(30), tlb_pkg::KIND_READ, 1'b0, 1);
        translate(page_addr(30), tlb_pkg::KIND_READ, 1'b0, 0);
        pt_mem[30] = make_pte(20'h4_4444, 1'b1, 1'b1, 1'b1, 1'b1);
        flush_tlb();
        translate(page_addr(30), tlb_pkg::KIND_READ, 1'b0, 1);

        // Back-pressure on responses and memory
        for (int i = 0; i < N_BP; i++) begin
            translate(page_addr(pick(PT_ENTRIES)), 2'(pick(3)), 1'b1, -1);
        end

        // Three pages into two ways
        for (int i = 0; i < N_REPL; i++) begin
            translate(page_addr(5 + 16 * pick(3)), 2'(pick(3)), 1'b1, -1);
        end

        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/tlb_pkg.sv
verilog/sv32_pkg.sv
verilog/tlb_lutram.sv
verilog/tlb.sv
verilog/page_walker.sv
verilog/mmu_ctrl.sv
verilog/mmu_top.sv
dv/mmu_sva.sv
dv/tb_mmu.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - verilog/tlb_pkg.sv
  - verilog/sv32_pkg.sv
  - verilog/tlb_lutram.sv
  - verilog/tlb.sv
  - verilog/page_walker.sv
  - verilog/mmu_ctrl.sv
  - verilog/mmu_top.sv
  - target: test
    files:
      - dv/mmu_sva.sv
      - dv/tb_mmu.sv
